// File: rtl/inv_pkg.sv
////////////////////
// Shared constants and types for the inverter control core.
// Timing lengths are in clk cycles. Import with inv_pkg::* where needed.
////////////////////
`default_nettype none

package inv_pkg;

    // Power module lines driven by the UART bank
    localparam int NUM_MODULES = 3;

    // Serial timing
    localparam int CLKS_PER_BIT = 4;
    localparam int SPI_HALF_CLKS = 2;
    localparam int BIT_TICK_W = $clog2(CLKS_PER_BIT);
    localparam int SPI_DIV_W = (SPI_HALF_CLKS > 1) ? $clog2(SPI_HALF_CLKS) : 1;

    // Sequencer intervals
    localparam int STARTUP_CLKS = 40;
    localparam int IDLE_CLKS = 120;
    localparam int GAP_CLKS = 30;

    // Pipe command word from the sine table source
    localparam logic [11:0] PIPE_CODE = 12'hFFF;
    localparam logic [3:0] PIPE_ID = 4'hA;

    // One word from the sine table, index in the upper bits
    typedef struct packed {
        logic [11:0] index;
        logic [3:0]  id;
    } sample_t;

    typedef enum logic [1:0] {
        MODE_INIT,
        MODE_IDLE,
        MODE_NORMAL,
        MODE_PIPE
    } ctrl_mode_e;

    typedef enum logic [3:0] {
        STARTUP,
        FIRST_READ,
        IDLE_WAIT,
        READ,
        SEND_HI,
        SEND_LO,
        SHOOT,
        GAP,
        PIPE
    } seq_state_e;

    typedef struct packed {
        logic sclk;
        logic cs_n;
    } spi_lines_t;

endpackage

`default_nettype wire

// File: rtl/interval_timer.sv
////////////////////
// Down-counting interval timer shared by the startup, idle and gap waits.
// Pulse tim_start with tim_len set; tim_done is high once the count is
// back at zero.
////////////////////
`default_nettype none

module interval_timer (
    input  logic        clk,
    input  logic        reset,
    input  logic        tim_start,
    input  logic [15:0] tim_len,
    output logic        tim_done
);

    logic [15:0] count_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            count_q <= '0;
        end else if (tim_start) begin
            count_q <= tim_len;
        end else if (count_q != '0) begin
            count_q <= count_q - 16'd1;
        end
    end

    // A load in flight hides the old zero count
    assign tim_done = (count_q == '0) && !tim_start;

endmodule

`default_nettype wire

// File: rtl/spi_sample_reader.sv
////////////////////
// SPI master that fetches one 16-bit sample word per request.
// Data is read MSB first on the rising sclk edge. The word stays on
// sample while spi_ack is high, and ack clears after spi_req drops.
////////////////////
`default_nettype none

module spi_sample_reader
    import inv_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       spi_req,
    input  logic       miso,
    output logic       spi_ack,
    output spi_lines_t spi_out,
    output sample_t    sample
);

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_SHIFT,
        RD_END,
        RD_ACK
    } rd_state_e;

    rd_state_e              rd_state;
    spi_lines_t             lines_q;
    logic [SPI_DIV_W-1:0]   div_q;
    logic [3:0]             bit_cnt;
    logic [15:0]            shift_q;
    logic                   half_end;

    assign half_end = (div_q == SPI_DIV_W'(SPI_HALF_CLKS - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_state <= RD_IDLE;
            lines_q.sclk <= 1'b0;
            lines_q.cs_n <= 1'b1;
            div_q <= '0;
            bit_cnt <= '0;
        end else begin
            case (rd_state)
                RD_IDLE: begin
                    if (spi_req) begin
                        rd_state <= RD_SHIFT;
                        lines_q.cs_n <= 1'b0;
                        div_q <= '0;
                        bit_cnt <= '0;
                    end
                end
                RD_SHIFT: begin
                    if (half_end) begin
                        div_q <= '0;
                        lines_q.sclk <= ~lines_q.sclk;
                        if (!lines_q.sclk) begin
                            // Rising sclk, slave data has settled
                            shift_q <= {shift_q[14:0], miso};
                        end else if (bit_cnt == 4'd15) begin
                            rd_state <= RD_END;
                            lines_q.cs_n <= 1'b1;
                        end else begin
                            bit_cnt <= bit_cnt + 4'd1;
                        end
                    end else begin
                        div_q <= div_q + 1'b1;
                    end
                end
                RD_END: begin
                    rd_state <= RD_ACK;
                end
                default: begin
                    // Hold the word until the sequencer lets go
                    if (!spi_req) begin
                        rd_state <= RD_IDLE;
                    end
                end
            endcase
        end
    end

    assign spi_ack = (rd_state == RD_ACK);
    assign spi_out = lines_q;
    assign sample = sample_t'(shift_q);

endmodule

`default_nettype wire

// File: rtl/uart_broadcast_tx.sv
////////////////////
// UART transmitter that broadcasts one byte to every power module.
// Frame is start, 8 data bits LSB first, even parity, stop.
// tx_ack rises after the stop bit and clears once tx_req is low.
////////////////////
`default_nettype none

module uart_broadcast_tx
    import inv_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   tx_req,
    input  logic [7:0]             tx_byte,
    output logic                   tx_ack,
    output logic [NUM_MODULES-1:0] tx_lines
);

    logic                  busy;
    logic [BIT_TICK_W-1:0] tick_q;
    logic [3:0]            bit_cnt;
    logic [10:0]           frame_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            tx_ack <= 1'b0;
            tick_q <= '0;
            bit_cnt <= '0;
        end else if (busy) begin
            if (tick_q == BIT_TICK_W'(CLKS_PER_BIT - 1)) begin
                tick_q <= '0;
                frame_q <= {1'b1, frame_q[10:1]};
                if (bit_cnt == 4'd10) begin
                    busy <= 1'b0;
                    tx_ack <= 1'b1;
                end else begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end else begin
                tick_q <= tick_q + 1'b1;
            end
        end else if (tx_ack) begin
            if (!tx_req) begin
                tx_ack <= 1'b0;
            end
        end else if (tx_req) begin
            busy <= 1'b1;
            tick_q <= '0;
            bit_cnt <= '0;
            // Stop, parity, data, start
            frame_q <= {1'b1, ^tx_byte, tx_byte, 1'b0};
        end
    end

    // Same level on every module line, idle high
    assign tx_lines = {NUM_MODULES{busy ? frame_q[0] : 1'b1}};

endmodule

`default_nettype wire

// File: rtl/frame_sequencer.sv
////////////////////
// Mode and frame state machine of the inverter controller.
// Runs the startup wait, checks the first word for the pipe command, then
// loops read, two UART bytes, shoot and gap. Talks to the SPI reader and
// the UART bank over four-phase req/ack.
////////////////////
`default_nettype none

module frame_sequencer
    import inv_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        tim_done,
    input  logic        spi_ack,
    input  sample_t     sample,
    input  logic        tx_ack,
    output logic        tim_start,
    output logic [15:0] tim_len,
    output logic        spi_req,
    output logic        tx_req,
    output logic [7:0]  tx_byte,
    output logic        shoot,
    output ctrl_mode_e  mode
);

    seq_state_e state;
    logic       tim_armed;
    logic       timed;
    sample_t    sample_q;

    assign timed = (state == STARTUP) || (state == IDLE_WAIT) || (state == GAP);

    // Load the timer once on entry to each timed state
    assign tim_start = timed && !tim_armed;

    always_comb begin
        case (state)
            STARTUP:   tim_len = 16'(STARTUP_CLKS);
            IDLE_WAIT: tim_len = 16'(IDLE_CLKS);
            default:   tim_len = 16'(GAP_CLKS);
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= STARTUP;
            tim_armed <= 1'b0;
            spi_req <= 1'b0;
            tx_req <= 1'b0;
        end else begin
            case (state)
                STARTUP, IDLE_WAIT, GAP: begin
                    if (!tim_armed) begin
                        tim_armed <= 1'b1;
                    end else if (tim_done) begin
                        tim_armed <= 1'b0;
                        state <= (state == STARTUP) ? FIRST_READ : READ;
                    end
                end
                FIRST_READ, READ: begin
                    if (!spi_req && !spi_ack) begin
                        spi_req <= 1'b1;
                    end else if (spi_req && spi_ack) begin
                        spi_req <= 1'b0;
                        sample_q <= sample;
                        if (state == READ) begin
                            state <= SEND_HI;
                        end else if (sample.index == PIPE_CODE && sample.id == PIPE_ID) begin
                            state <= PIPE;
                        end else begin
                            state <= IDLE_WAIT;
                        end
                    end
                end
                SEND_HI, SEND_LO: begin
                    if (!tx_req && !tx_ack) begin
                        tx_req <= 1'b1;
                    end else if (tx_req && tx_ack) begin
                        tx_req <= 1'b0;
                        state <= (state == SEND_HI) ? SEND_LO : SHOOT;
                    end
                end
                SHOOT: begin
                    state <= GAP;
                end
                default: begin
                    // Pipe mode is terminal
                    state <= PIPE;
                end
            endcase
        end
    end

    // High byte first, then low nibble with the module id
    assign tx_byte = (state == SEND_LO) ? {sample_q.index[3:0], sample_q.id}
                                        : sample_q.index[11:4];

    assign shoot = (state == SHOOT);

    always_comb begin
        case (state)
            STARTUP, FIRST_READ: mode = MODE_INIT;
            IDLE_WAIT:           mode = MODE_IDLE;
            PIPE:                mode = MODE_PIPE;
            default:             mode = MODE_NORMAL;
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/inverter_ctrl_top.sv
////////////////////
// Top level of the inverter control core.
// Connects the sequencer, interval timer, SPI sample reader and the UART
// broadcast bank on a single clock.
////////////////////
`default_nettype none

module inverter_ctrl_top
    import inv_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   miso,
    output spi_lines_t             spi_out,
    output logic [NUM_MODULES-1:0] tx_lines,
    output logic                   shoot,
    output ctrl_mode_e             mode
);

    logic        tim_start;
    logic [15:0] tim_len;
    logic        tim_done;
    logic        spi_req;
    logic        spi_ack;
    sample_t     sample;
    logic        tx_req;
    logic        tx_ack;
    logic [7:0]  tx_byte;

    frame_sequencer u_seq (
        .clk       (clk),
        .reset     (reset),
        .tim_done  (tim_done),
        .spi_ack   (spi_ack),
        .sample    (sample),
        .tx_ack    (tx_ack),
        .tim_start (tim_start),
        .tim_len   (tim_len),
        .spi_req   (spi_req),
        .tx_req    (tx_req),
        .tx_byte   (tx_byte),
        .shoot     (shoot),
        .mode      (mode)
    );

    interval_timer u_timer (
        .clk       (clk),
        .reset     (reset),
        .tim_start (tim_start),
        .tim_len   (tim_len),
        .tim_done  (tim_done)
    );

    spi_sample_reader u_spi (
        .clk     (clk),
        .reset   (reset),
        .spi_req (spi_req),
        .miso    (miso),
        .spi_ack (spi_ack),
        .spi_out (spi_out),
        .sample  (sample)
    );

    uart_broadcast_tx u_uart (
        .clk      (clk),
        .reset    (reset),
        .tx_req   (tx_req),
        .tx_byte  (tx_byte),
        .tx_ack   (tx_ack),
        .tx_lines (tx_lines)
    );

endmodule

`default_nettype wire

// File: tb/inverter_ctrl_assert.sv
////////////////////
// Concurrent assertions on the sequencer handshakes and shoot pulse.
// Bound into every frame_sequencer instance.
////////////////////
`default_nettype none

module inverter_ctrl_assert (
    input logic clk,
    input logic reset,
    input logic spi_req,
    input logic spi_ack,
    input logic tx_req,
    input logic tx_ack,
    input logic shoot
);

    // Request stays up until the reader answers
    a_spi_hold: assert property (@(posedge clk) disable iff (reset)
        spi_req && !spi_ack |=> spi_req)
        else $error("spi_req dropped before spi_ack");

    a_spi_rise: assert property (@(posedge clk) disable iff (reset)
        $rose(spi_req) |-> !spi_ack)
        else $error("spi_req rose while spi_ack high");

    a_tx_rise: assert property (@(posedge clk) disable iff (reset)
        $rose(tx_req) |-> !tx_ack)
        else $error("tx_req rose while tx_ack high");

    a_shoot_len: assert property (@(posedge clk) disable iff (reset)
        shoot |=> !shoot)
        else $error("shoot high for more than one cycle");

endmodule

bind frame_sequencer inverter_ctrl_assert u_assert (
    .clk     (clk),
    .reset   (reset),
    .spi_req (spi_req),
    .spi_ack (spi_ack),
    .tx_req  (tx_req),
    .tx_ack  (tx_ack),
    .shoot   (shoot)
);

`default_nettype wire

// File: tb/tb_inverter_ctrl.sv
////////////////////
// Testbench for the inverter control core.
// Models the SPI sine-table source, decodes the UART lines and checks
// each normal frame from a stimulus table, then checks pipe mode after
// a second reset.
////////////////////
`default_nettype none

module tb_inverter_ctrl
    import inv_pkg::*;
();

    localparam int NUM_ROWS = 8;
    localparam int unsigned RAND_SEED = 32'hed5d3686;
    // One SPI read, two UART bytes and some handshake cycles
    localparam int FRAME_CLKS = 16 * 2 * SPI_HALF_CLKS + 2 + 2 * (11 * CLKS_PER_BIT + 1) + 12;
    localparam int PIPE_WINDOW = IDLE_CLKS + FRAME_CLKS + GAP_CLKS;
    localparam int WATCH_CLKS = 2 * (NUM_ROWS * (FRAME_CLKS + GAP_CLKS) + STARTUP_CLKS
                                + IDLE_CLKS) + PIPE_WINDOW + STARTUP_CLKS + FRAME_CLKS;
    localparam logic [15:0] FIRST_WORD = 16'h1234;
    localparam spi_lines_t SPI_IDLE = '{sclk: 1'b0, cs_n: 1'b1};

    logic                   clk;
    logic                   reset;
    logic                   miso;
    spi_lines_t             spi_out;
    logic [NUM_MODULES-1:0] tx_lines;
    logic                   shoot;
    ctrl_mode_e             mode;

    // Stimulus table with one row per normal frame
    string      row_name [NUM_ROWS];
    sample_t    row_word [NUM_ROWS];
    logic [7:0] row_hi   [NUM_ROWS];
    logic [7:0] row_lo   [NUM_ROWS];
    ctrl_mode_e row_mode [NUM_ROWS];

    logic [15:0] spi_words [$];
    logic [7:0]  rx_q [$];
    logic [15:0] cur_word;
    int          bit_idx;
    int          read_cnt;
    spi_lines_t  prev_spi;
    logic        prev_line;
    logic [10:0] rx_bits;
    string       cur_name;
    int          err_cnt;
    int          err_base;
    int          tests_run;
    int          tests_failed;
    int          wait_cycles;
    logic [7:0]  rx_hi;
    logic [7:0]  rx_lo;
    logic        shoot_seen;
    logic        line_seen;

    inverter_ctrl_top u_dut (
        .clk      (clk),
        .reset    (reset),
        .miso     (miso),
        .spi_out  (spi_out),
        .tx_lines (tx_lines),
        .shoot    (shoot),
        .mode     (mode)
    );

    always #2 clk = ~clk;

    task automatic check_byte(input string what, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            $display("** Error %s %s: expected %02h, actual %02h", cur_name, what, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_mode(input string what, input ctrl_mode_e exp, input ctrl_mode_e act);
        if (act !== exp) begin
            $display("** Error %s %s: expected %s, actual %s", cur_name, what, exp.name(),
                     act.name());
            err_cnt++;
        end
    endtask

    task automatic check_parity(input string what, input logic [7:0] data, input logic act);
        logic exp;
        // Parity bit brings the total count of ones to an even number
        exp = ($countones(data) % 2) != 0;
        if (act !== exp) begin
            $display("** Error %s %s: expected %b, actual %b", cur_name, what, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_spi(input string what, input spi_lines_t exp, input spi_lines_t act);
        if (act !== exp) begin
            $display("** Error %s %s: expected %02b, actual %02b", cur_name, what, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_count(input string what, input int exp, input int act);
        if (act != exp) begin
            $display("** Error %s %s: expected %0d, actual %0d", cur_name, what, exp, act);
            err_cnt++;
        end
    endtask

    task automatic report(input string msg);
        $display("%s: %s", cur_name, msg);
        err_cnt++;
    endtask

    task automatic start_test(input string name);
        cur_name = name;
        err_base = err_cnt;
    endtask

    task automatic end_test();
        tests_run++;
        if (err_cnt != err_base) begin
            tests_failed++;
            $display("test %-14s failed", cur_name);
        end else begin
            $display("test %-14s ok", cur_name);
        end
    endtask

    // Index sits in word bits 15..4, so the bytes are the two word halves
    task automatic set_row(input int i, input string name, input logic [15:0] w);
        row_name[i] = name;
        row_word[i] = sample_t'(w);
        row_hi[i] = w[15:8];
        row_lo[i] = w[7:0];
        row_mode[i] = MODE_NORMAL;
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #1 reset = 1'b1;
        repeat (4) @(posedge clk);
        #1 reset = 1'b0;
    endtask

    // SPI slave model shifting out the next word on each cs_n fall
    always @(posedge clk) begin
        #1;
        if (prev_spi.cs_n && !spi_out.cs_n) begin
            if (spi_words.size() > 0) begin
                cur_word = spi_words.pop_front();
            end else begin
                cur_word = 16'h0000;
            end
            bit_idx = 15;
            miso = cur_word[15];
            read_cnt++;
        end else if (!spi_out.cs_n && prev_spi.sclk && !spi_out.sclk && bit_idx > 0) begin
            bit_idx--;
            miso = cur_word[bit_idx];
        end
        prev_spi = spi_out;
    end

    // UART decoder sampling line 0 at bit centers
    always @(negedge clk) begin
        if (prev_line === 1'b1 && tx_lines[0] === 1'b0) begin
            for (int k = 0; k < 11; k++) begin
                repeat ((k == 0) ? 2 : 4) @(negedge clk);
                rx_bits[k] = tx_lines[0];
                if (tx_lines !== {NUM_MODULES{tx_lines[0]}}) begin
                    report("module lines differ within a UART frame");
                end
            end
            if (rx_bits[0] !== 1'b0) begin
                report("start bit not held low");
            end
            check_parity("parity bit", rx_bits[8:1], rx_bits[9]);
            if (rx_bits[10] !== 1'b1) begin
                report("stop bit is not high");
            end
            rx_q.push_back(rx_bits[8:1]);
        end
        prev_line = tx_lines[0];
    end

    initial begin
        repeat (WATCH_CLKS) @(posedge clk);
        $display("watchdog expired after %0d cycles", WATCH_CLKS);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        miso = 1'b0;
        prev_spi = SPI_IDLE;
        prev_line = 1'b1;
        void'($urandom(RAND_SEED));
        set_row(0, "zero_word", 16'h0000);
        set_row(1, "high_word", 16'hFFF5);
        set_row(2, "mixed_word", 16'h5A3C);
        for (int k = 3; k < NUM_ROWS; k++) begin
            set_row(k, $sformatf("random_%0d", k - 3), 16'($urandom()));
        end
        spi_words.push_back(FIRST_WORD);
        for (int k = 0; k < NUM_ROWS; k++) begin
            spi_words.push_back(row_word[k]);
        end

        start_test("reset_state");
        apply_reset();
        @(negedge clk);
        check_spi("spi lines", SPI_IDLE, spi_out);
        check_mode("mode", MODE_INIT, mode);
        if (tx_lines !== '1 || shoot !== 1'b0) begin
            report("UART lines not idle high or shoot not low after reset");
        end
        end_test();

        start_test("startup_read");
        wait_cycles = 0;
        while (read_cnt == 0) begin
            @(negedge clk);
            wait_cycles++;
        end
        if (wait_cycles < STARTUP_CLKS || wait_cycles > STARTUP_CLKS + 8) begin
            report($sformatf("first SPI read came %0d cycles after reset", wait_cycles));
        end
        check_mode("mode at first read", MODE_INIT, mode);
        end_test();

        start_test("idle_to_normal");
        while (mode == MODE_INIT) @(negedge clk);
        check_mode("mode after first read", MODE_IDLE, mode);
        wait_cycles = 0;
        while (mode == MODE_IDLE) begin
            @(negedge clk);
            wait_cycles++;
        end
        check_mode("mode after idle", MODE_NORMAL, mode);
        if (wait_cycles < IDLE_CLKS) begin
            report($sformatf("idle interval lasted only %0d cycles", wait_cycles));
        end
        end_test();

        for (int i = 0; i < NUM_ROWS; i++) begin
            start_test(row_name[i]);
            while (shoot !== 1'b1) @(negedge clk);
            check_count("bytes before shoot", 2, rx_q.size());
            if (rx_q.size() >= 2) begin
                rx_hi = rx_q.pop_front();
                rx_lo = rx_q.pop_front();
                check_byte("high byte", row_hi[i], rx_hi);
                check_byte("low byte", row_lo[i], rx_lo);
            end
            rx_q.delete();
            check_mode("mode", row_mode[i], mode);
            check_count("spi reads", i + 2, read_cnt);
            @(negedge clk);
            end_test();
        end

        // Second reset during the gap with the pipe command as first word
        start_test("pipe_mode");
        spi_words.delete();
        spi_words.push_back({PIPE_CODE, PIPE_ID});
        apply_reset();
        read_cnt = 0;
        while (mode !== MODE_PIPE) @(negedge clk);
        check_count("spi reads", 1, read_cnt);
        shoot_seen = 1'b0;
        line_seen = 1'b0;
        repeat (PIPE_WINDOW) begin
            @(negedge clk);
            shoot_seen |= shoot;
            line_seen |= (tx_lines !== '1);
        end
        if (shoot_seen) begin
            report("shoot pulse seen in pipe mode");
        end
        if (line_seen) begin
            report("UART start bit seen in pipe mode");
        end
        check_mode("mode", MODE_PIPE, mode);
        end_test();

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
        if (err_cnt == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
rtl/inv_pkg.sv
rtl/interval_timer.sv
rtl/spi_sample_reader.sv
rtl/uart_broadcast_tx.sv
rtl/frame_sequencer.sv
rtl/inverter_ctrl_top.sv
tb/inverter_ctrl_assert.sv
tb/tb_inverter_ctrl.sv

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and pass only on the pass message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 --top-module tb_inverter_ctrl -f files.f || exit 1
out=$(./obj_dir/Vtb_inverter_ctrl 2>&1)
echo "$out"
echo "$out" | grep -q "Simulation PASSED" && exit 0 || exit 1
